// ==== src/core_s2_defs.svh ====
`ifndef CORE_S2_DEFS_SVH
`define CORE_S2_DEFS_SVH

// Width of one data word and of every register
`define CORE_S2_DATA_W 32

// Architectural registers, register 0 reads as zero
`define CORE_S2_REG_COUNT 16

// Words held in the L1 data cache array
`define CORE_S2_DMEM_DEPTH 64

// Cycles the timer counts for one cache access
// Must be at least 1
`define CORE_S2_DCACHE_LATENCY 3

`endif

// ==== src/core_pkg.sv ====
package core_pkg;

`include "core_s2_defs.svh"

    // Data word as seen by registers, ALU and cache
    typedef logic [`CORE_S2_DATA_W-1:0] word_t;

    // Register index
    typedef logic [$clog2(`CORE_S2_REG_COUNT)-1:0] reg_idx_t;

    // Immediate, sign-extended by the ALU
    typedef logic signed [15:0] imm_t;

    // Word address into the data array
    typedef logic [$clog2(`CORE_S2_DMEM_DEPTH)-1:0] dmem_addr_t;

    // Operation code, unlisted codes behave as HALT
    typedef logic [3:0] opcode_t;

    localparam opcode_t OP_ADD   = 4'd0;
    localparam opcode_t OP_SUB   = 4'd1;
    localparam opcode_t OP_AND   = 4'd2;
    localparam opcode_t OP_OR    = 4'd3;
    localparam opcode_t OP_XOR   = 4'd4;
    localparam opcode_t OP_ADDI  = 4'd5;
    localparam opcode_t OP_LOAD  = 4'd6;
    localparam opcode_t OP_STORE = 4'd7;
    localparam opcode_t OP_HALT  = 4'd15;

    // Decoded instruction handed over by stage 1
    typedef struct packed {
        opcode_t  opcode;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        imm_t     imm;
    } s2_instr_s;

    // Control bits from the FSM to the datapath
    typedef struct packed {
        logic rd_write_enable;
        logic rd_from_mem;
        logic mem_start;
        logic mem_write;
    } s2_ctrl_s;

endpackage : core_pkg

// ==== src/core_s2_control.sv ====
`timescale 1ns/1ps

module core_s2_control (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  core_pkg::opcode_t cur_opcode,
    input  logic              mem_done,
    output logic              instr_ack,
    output core_pkg::s2_ctrl_s ctrl,
    output logic              halted
);

    import core_pkg::*;

    // Stage 2 states
    typedef enum logic [2:0] {
        INIT,
        HALT,
        FETCH_NEXT,
        WAIT_ON_L1DCACHE,
        FINISH_CURRENT_AND_FETCH_NEXT
    } state_e;

    state_e state;
    state_e next_state;

    // High in the first cycle spent in WAIT_ON_L1DCACHE
    logic first_wait;

    always_ff @(posedge clk or negedge rst_n) begin : state_ff
        if (!rst_n) begin
            state      <= INIT;
            first_wait <= 1'b0;
        end else begin
            state      <= next_state;
            first_wait <= (state != WAIT_ON_L1DCACHE) && (next_state == WAIT_ON_L1DCACHE);
        end
    end : state_ff

    always_comb begin : next_state_logic
        next_state = state;
        case (state)
            INIT: begin
                // Single setup cycle
                next_state = FETCH_NEXT;
            end
            HALT: begin
                // Only reset leaves HALT
                next_state = HALT;
            end
            FETCH_NEXT: begin
                if (instr_valid) begin
                    // Path chosen from the opcode being accepted
                    case (cur_opcode)
                        OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_ADDI: begin
                            next_state = FINISH_CURRENT_AND_FETCH_NEXT;
                        end
                        OP_LOAD, OP_STORE: begin
                            next_state = WAIT_ON_L1DCACHE;
                        end
                        default: begin
                            // HALT and unknown codes
                            next_state = HALT;
                        end
                    endcase
                end
            end
            WAIT_ON_L1DCACHE: begin
                // Leave once the timer flags the access done
                if (mem_done) begin
                    next_state = FINISH_CURRENT_AND_FETCH_NEXT;
                end
            end
            FINISH_CURRENT_AND_FETCH_NEXT: begin
                next_state = FETCH_NEXT;
            end
            default: begin
                // Illegal encoding, stop the core
                next_state = HALT;
            end
        endcase
    end : next_state_logic

    always_comb begin : control_signal_logic
        instr_ack = 1'b0;
        ctrl      = '0;
        case (state)
            FETCH_NEXT: begin
                // Accept pulse, one cycle since the state moves on
                instr_ack = instr_valid;
            end
            WAIT_ON_L1DCACHE: begin
                // Kick the timer on entry only
                ctrl.mem_start = first_wait;
                ctrl.mem_write = (cur_opcode == OP_STORE);
            end
            FINISH_CURRENT_AND_FETCH_NEXT: begin
                // Stores have no destination
                ctrl.rd_write_enable = (cur_opcode != OP_STORE);
                ctrl.rd_from_mem     = (cur_opcode == OP_LOAD);
            end
            default: begin
                // INIT, HALT and illegal states drive nothing
            end
        endcase
    end : control_signal_logic

    assign halted = (state == HALT);

endmodule : core_s2_control

// ==== src/core_s2_mem_timer.sv ====
`timescale 1ns/1ps

`include "core_s2_defs.svh"

module core_s2_mem_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    output logic done
);

    // Wide enough to hold the full latency
    localparam int CNT_W = $clog2(`CORE_S2_DCACHE_LATENCY + 1);

    logic [CNT_W-1:0] count;

    always_ff @(posedge clk or negedge rst_n) begin : count_ff
        if (!rst_n) begin
            count <= '0;
        end else if (start) begin
            count <= CNT_W'(`CORE_S2_DCACHE_LATENCY);
        end else if (count != '0) begin
            // Count down, then rest at zero
            count <= count - CNT_W'(1);
        end
    end : count_ff

    // Last cycle of the access, the count hits zero at the next edge
    assign done = (count == CNT_W'(1));

endmodule : core_s2_mem_timer

// ==== src/core_s2_regfile.sv ====
`timescale 1ns/1ps

`include "core_s2_defs.svh"

module core_s2_regfile (
    input  logic               clk,
    input  logic               rst_n,
    input  core_pkg::reg_idx_t rs1_idx,
    input  core_pkg::reg_idx_t rs2_idx,
    output core_pkg::word_t    rs1_data,
    output core_pkg::word_t    rs2_data,
    input  core_pkg::reg_idx_t rd_idx,
    input  core_pkg::word_t    rd_data,
    input  logic               rd_write_enable,
    input  core_pkg::reg_idx_t dbg_idx,
    output core_pkg::word_t    dbg_data
);

    import core_pkg::*;

    word_t regs [`CORE_S2_REG_COUNT];

    always_ff @(posedge clk or negedge rst_n) begin : regs_ff
        if (!rst_n) begin
            for (int i = 0; i < `CORE_S2_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_write_enable && (rd_idx != '0)) begin
            // Register 0 keeps its reset value of zero
            regs[rd_idx] <= rd_data;
        end
    end : regs_ff

    // Asynchronous reads
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    // Debug view of the architectural state
    assign dbg_data = regs[dbg_idx];

endmodule : core_s2_regfile

// ==== src/core_s2_alu.sv ====
`timescale 1ns/1ps

module core_s2_alu (
    input  core_pkg::opcode_t opcode,
    input  core_pkg::word_t   a,
    input  core_pkg::word_t   b,
    input  core_pkg::imm_t    imm,
    output core_pkg::word_t   result
);

    import core_pkg::*;

    // Immediate widened to a full word
    word_t imm_ext;

    assign imm_ext = {{($bits(word_t) - $bits(imm_t)){imm[$bits(imm_t)-1]}}, imm};

    always_comb begin : alu_logic
        case (opcode)
            OP_ADD: result = a + b;
            OP_SUB: result = a - b;
            OP_AND: result = a & b;
            OP_OR:  result = a | b;
            OP_XOR: result = a ^ b;
            // Immediate add, also the load and store address
            OP_ADDI, OP_LOAD, OP_STORE: begin
                result = a + imm_ext;
            end
            default: begin
                // HALT and unknown codes
                result = '0;
            end
        endcase
    end : alu_logic

endmodule : core_s2_alu

// ==== src/core_s2_l1dcache.sv ====
`timescale 1ns/1ps

`include "core_s2_defs.svh"

module core_s2_l1dcache (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 access,
    input  logic                 write,
    input  core_pkg::dmem_addr_t addr,
    input  core_pkg::word_t      wdata,
    output core_pkg::word_t      rdata
);

    import core_pkg::*;

    // Always hits, so the array is the whole cache
    word_t mem [`CORE_S2_DMEM_DEPTH];

    always_ff @(posedge clk) begin : array_ff
        if (access && write) begin
            mem[addr] <= wdata;
        end
    end : array_ff

    always_ff @(posedge clk or negedge rst_n) begin : rdata_ff
        if (!rst_n) begin
            rdata <= '0;
        end else if (access && !write) begin
            // Held until the next load
            rdata <= mem[addr];
        end
    end : rdata_ff

endmodule : core_s2_l1dcache

// ==== src/core_s2.sv ====
`timescale 1ns/1ps

module core_s2 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                instr_valid,
    input  core_pkg::s2_instr_s instr,
    output logic                instr_ack,
    output logic                halted,
    input  core_pkg::reg_idx_t  dbg_idx,
    output core_pkg::word_t     dbg_data
);

    import core_pkg::*;

    // Instruction being executed
    s2_instr_s  cur_instr;
    opcode_t    cur_opcode;
    s2_ctrl_s   ctrl;
    logic       mem_done;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      alu_result;
    word_t      mem_rdata;
    word_t      rd_data;
    dmem_addr_t mem_addr;

    // Latch on accept, stage 1 holds instr stable until then
    always_ff @(posedge clk) begin : cur_instr_ff
        if (instr_ack) begin
            cur_instr <= instr;
        end
    end : cur_instr_ff

    // Incoming opcode in the accept cycle, latched opcode otherwise
    assign cur_opcode = instr_ack ? instr.opcode : cur_instr.opcode;

    core_s2_control u_control (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .cur_opcode  (cur_opcode),
        .mem_done    (mem_done),
        .instr_ack   (instr_ack),
        .ctrl        (ctrl),
        .halted      (halted)
    );

    core_s2_mem_timer u_mem_timer (
        .clk   (clk),
        .rst_n (rst_n),
        .start (ctrl.mem_start),
        .done  (mem_done)
    );

    core_s2_regfile u_regfile (
        .clk             (clk),
        .rst_n           (rst_n),
        .rs1_idx         (cur_instr.rs1),
        .rs2_idx         (cur_instr.rs2),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data),
        .rd_idx          (cur_instr.rd),
        .rd_data         (rd_data),
        .rd_write_enable (ctrl.rd_write_enable),
        .dbg_idx         (dbg_idx),
        .dbg_data        (dbg_data)
    );

    core_s2_alu u_alu (
        .opcode (cur_instr.opcode),
        .a      (rs1_data),
        .b      (rs2_data),
        .imm    (cur_instr.imm),
        .result (alu_result)
    );

    // Low bits of the computed address pick the word
    assign mem_addr = alu_result[$bits(dmem_addr_t)-1:0];

    core_s2_l1dcache u_l1dcache (
        .clk   (clk),
        .rst_n (rst_n),
        .access(mem_done),
        .write (ctrl.mem_write),
        .addr  (mem_addr),
        .wdata (rs2_data),
        .rdata (mem_rdata)
    );

    // Writeback source, loads take the registered cache data
    assign rd_data = ctrl.rd_from_mem ? mem_rdata : alu_result;

endmodule : core_s2

// ==== dv/core_s2_assertions.sv ====
`timescale 1ns/1ps

module core_s2_assertions (
    input logic clk,
    input logic rst_n,
    input logic instr_valid,
    input logic instr_ack,
    input logic halted
);

    // Accept only while stage 1 offers an instruction
    ack_needs_valid: assert property (@(posedge clk) disable iff (!rst_n)
        instr_ack |-> instr_valid)
        else $error("instr_ack without instr_valid");

    // Accept is a single-cycle pulse
    ack_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        instr_ack |=> !instr_ack)
        else $error("instr_ack high on two consecutive cycles");

    // HALT is final until reset
    halt_is_final: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> (halted && !instr_ack))
        else $error("halted dropped or instr_ack seen after halt");

endmodule : core_s2_assertions

bind core_s2 core_s2_assertions u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr_ack   (instr_ack),
    .halted      (halted)
);

// ==== dv/core_s2_tb.sv ====
`timescale 1ns/1ps

`include "core_s2_defs.svh"

module core_s2_tb;

    import core_pkg::*;

    // Longest wait for any DUT event in cycles
    localparam int TIMEOUT_CYCLES = 100;

    logic      clk;
    logic      rst_n;
    logic      instr_valid;
    s2_instr_s instr;
    logic      instr_ack;
    logic      halted;
    reg_idx_t  dbg_idx;
    word_t     dbg_data;

    // Reference model of the architectural state
    word_t model_regs [`CORE_S2_REG_COUNT];
    word_t model_mem [`CORE_S2_DMEM_DEPTH];
    logic  written [`CORE_S2_DMEM_DEPTH];

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;
    int          cycle_cnt = 0;
    int          last_accept;

    core_s2 uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ack   (instr_ack),
        .halted      (halted),
        .dbg_idx     (dbg_idx),
        .dbg_data    (dbg_data)
    );

    initial begin : clock_gen
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end : clock_gen

    // Cycle numbers for accept spacing
    always @(posedge clk) begin : cycle_counter
        cycle_cnt <= cycle_cnt + 1;
    end : cycle_counter

    // Galois LFSR with taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = next_lfsr(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    function automatic s2_instr_s make_instr(input opcode_t op, input reg_idx_t rd,
                                             input reg_idx_t rs1, input reg_idx_t rs2,
                                             input imm_t imm);
        s2_instr_s ins;
        ins.opcode = op;
        ins.rd     = rd;
        ins.rs1    = rs1;
        ins.rs2    = rs2;
        ins.imm    = imm;
        return ins;
    endfunction

    function automatic word_t sign_extend(input imm_t imm);
        return {{16{imm[15]}}, imm};
    endfunction

    // Apply one retired instruction to the model
    function automatic void model_exec(input s2_instr_s ins);
        word_t      a;
        word_t      b;
        word_t      res;
        dmem_addr_t addr;
        a    = model_regs[ins.rs1];
        b    = model_regs[ins.rs2];
        addr = dmem_addr_t'(a + sign_extend(ins.imm));
        case (ins.opcode)
            OP_ADD:  res = a + b;
            OP_SUB:  res = a - b;
            OP_AND:  res = a & b;
            OP_OR:   res = a | b;
            OP_XOR:  res = a ^ b;
            OP_ADDI: res = a + sign_extend(ins.imm);
            OP_LOAD: res = model_mem[addr];
            default: res = '0;
        endcase
        if (ins.opcode == OP_STORE) begin
            model_mem[addr] = b;
            written[addr]   = 1'b1;
        end else if (ins.opcode != OP_HALT && ins.rd != '0) begin
            model_regs[ins.rd] = res;
        end
    endfunction

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("** Error [%s] expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Errors: %0d of %0d checks", errors, checks);
        $display("Test failed");
        $finish;
    endtask

    // Entered and left 1 ns after a rising edge
    task automatic issue_instr(input s2_instr_s ins);
        int waited;
        waited      = 0;
        instr       = ins;
        instr_valid = 1'b1;
        @(negedge clk);
        while (!instr_ack) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_timeout("instr_ack");
            end
            @(negedge clk);
        end
        last_accept = cycle_cnt;
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
    endtask

    task automatic exec(input s2_instr_s ins);
        issue_instr(ins);
        model_exec(ins);
    endtask

    // Accept of a write to r0 proves every older instruction retired
    task automatic wait_retired();
        issue_instr(make_instr(OP_ADD, 4'd0, 4'd0, 4'd0, 16'sd0));
    endtask

    // One register per cycle through the debug port
    task automatic verify_regs(input string name);
        for (int i = 0; i < `CORE_S2_REG_COUNT; i++) begin
            dbg_idx = reg_idx_t'(i);
            @(negedge clk);
            check(name, model_regs[i], dbg_data);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic test_reset();
        check("reset halted", 32'd0, 32'(halted));
        check("reset ack", 32'd0, 32'(instr_ack));
        verify_regs("reset regs");
    endtask

    task automatic test_alu();
        int prev;
        exec(make_instr(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'sd100));
        exec(make_instr(OP_ADDI, 4'd2, 4'd0, 4'd0, imm_t'(-5)));
        exec(make_instr(OP_ADDI, 4'd3, 4'd0, 4'd0, 16'sh7fff));
        exec(make_instr(OP_ADDI, 4'd4, 4'd0, 4'd0, imm_t'(-32768)));
        prev = last_accept;
        exec(make_instr(OP_ADD, 4'd5, 4'd1, 4'd2, 16'sd0));
        // ALU op retires in one cycle, so accepts are two apart
        check("alu accept gap", 32'd2, last_accept - prev);
        exec(make_instr(OP_SUB, 4'd6, 4'd1, 4'd2, 16'sd0));
        exec(make_instr(OP_AND, 4'd7, 4'd3, 4'd2, 16'sd0));
        exec(make_instr(OP_OR, 4'd8, 4'd4, 4'd1, 16'sd0));
        exec(make_instr(OP_XOR, 4'd9, 4'd3, 4'd4, 16'sd0));
        wait_retired();
        verify_regs("alu regs");
    endtask

    task automatic test_zero_reg();
        exec(make_instr(OP_ADDI, 4'd0, 4'd0, 4'd0, 16'sd77));
        exec(make_instr(OP_ADD, 4'd0, 4'd1, 4'd3, 16'sd0));
        exec(make_instr(OP_STORE, 4'd0, 4'd0, 4'd1, 16'sd5));
        exec(make_instr(OP_LOAD, 4'd0, 4'd0, 4'd0, 16'sd5));
        wait_retired();
        dbg_idx = '0;
        @(negedge clk);
        check("r0 stays zero", 32'd0, dbg_data);
        @(posedge clk);
        #1;
        verify_regs("r0 regs");
    endtask

    task automatic test_load_store();
        dmem_addr_t base;
        dmem_addr_t addrs [4];
        word_t      vals [4];
        int         prev;
        base = dmem_addr_t'(rand_bits(6));
        for (int k = 0; k < 4; k++) begin
            // Spaced by 16 so the four words never overlap
            addrs[k] = base + dmem_addr_t'(16 * k);
            exec(make_instr(OP_ADDI, 4'd10, 4'd0, 4'd0, imm_t'(rand_bits(16))));
            vals[k] = model_regs[10];
            exec(make_instr(OP_STORE, 4'd0, 4'd0, 4'd10, imm_t'(addrs[k])));
            prev = last_accept;
            exec(make_instr(OP_ADD, 4'd0, 4'd0, 4'd0, 16'sd0));
            check("store accept gap", `CORE_S2_DCACHE_LATENCY + 3, last_accept - prev);
        end
        for (int k = 0; k < 4; k++) begin
            exec(make_instr(OP_LOAD, reg_idx_t'(11 + k), 4'd0, 4'd0, imm_t'(addrs[k])));
            prev = last_accept;
            wait_retired();
            check("load accept gap", `CORE_S2_DCACHE_LATENCY + 3, last_accept - prev);
            dbg_idx = reg_idx_t'(11 + k);
            #1;
            check("load data", vals[k], dbg_data);
            @(posedge clk);
            #1;
        end
        verify_regs("load store regs");
    endtask

    task automatic test_random_mix();
        s2_instr_s  ins;
        logic [2:0] kind;
        dmem_addr_t addr;
        for (int n = 0; n < 40; n++) begin
            kind = 3'(rand_bits(3));
            ins  = make_instr(OP_ADD, reg_idx_t'(rand_bits(4)), reg_idx_t'(rand_bits(4)),
                              reg_idx_t'(rand_bits(4)), imm_t'(rand_bits(16)));
            case (kind)
                3'd0: ins.opcode = OP_ADD;
                3'd1: ins.opcode = OP_SUB;
                3'd2: ins.opcode = OP_AND;
                3'd3: ins.opcode = OP_OR;
                3'd4: ins.opcode = OP_XOR;
                3'd5: ins.opcode = OP_ADDI;
                3'd6: begin
                    // Loads only from words the model already holds
                    ins.opcode = OP_LOAD;
                    addr = dmem_addr_t'(rand_bits(6));
                    while (!written[addr]) begin
                        addr++;
                    end
                    ins.rs1 = '0;
                    ins.imm = imm_t'(addr);
                end
                default: ins.opcode = OP_STORE;
            endcase
            exec(ins);
        end
        wait_retired();
        verify_regs("random regs");
    endtask

    task automatic test_halt();
        int waited;
        exec(make_instr(OP_HALT, 4'd0, 4'd0, 4'd0, 16'sd0));
        waited = 0;
        @(negedge clk);
        while (!halted) begin
            waited++;
            if (waited > TIMEOUT_CYCLES) begin
                report_timeout("halted");
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        // Held valid but never to be taken
        instr       = make_instr(OP_ADDI, 4'd1, 4'd0, 4'd0, 16'sd1);
        instr_valid = 1'b1;
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            check("halt no accept", 32'd0, 32'(instr_ack));
            check("halt sticky", 32'd1, 32'(halted));
        end
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        verify_regs("halt regs");
    endtask

    initial begin : main
        lfsr_state  = 32'h8084;
        errors      = 0;
        checks      = 0;
        last_accept = 0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        dbg_idx     = '0;
        for (int i = 0; i < `CORE_S2_REG_COUNT; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < `CORE_S2_DMEM_DEPTH; i++) begin
            model_mem[i] = '0;
            written[i]   = 1'b0;
        end
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_alu();
        test_zero_reg();
        test_load_store();
        test_random_mix();
        test_halt();
        $display("Errors: %0d of %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end : main

endmodule : core_s2_tb

// ==== sources.f ====
+incdir+src
src/core_pkg.sv
src/core_s2_control.sv
src/core_s2_mem_timer.sv
src/core_s2_regfile.sv
src/core_s2_alu.sv
src/core_s2_l1dcache.sv
src/core_s2.sv
dv/core_s2_assertions.sv
dv/core_s2_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert \
    --top-module core_s2_tb -Mdir obj_dir -o core_s2_sim \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/core_s2_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
